//--- hw/cpu18_pkg.sv
package cpu18_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;
	localparam int NUM_REGS = 16;
	localparam int RAM_SIZE = 256;

	// Memory map
	localparam logic [ADDR_W-1:0] RAM_BASE = 16'h8000;
	localparam logic [ADDR_W-1:0] OUT_PORT_ADDR = 16'hFFF0;

	// High nibble of the instruction, missing groups run as NOP
	typedef enum logic [3:0] {
		IDL_LDN = 4'h0, // IDL when N is zero
		INC = 4'h1,
		DEC = 4'h2,
		BRANCH = 4'h3,  // short branches
		LDA = 4'h4,
		STR = 4'h5,
		GROUP7 = 4'h7,  // REQ and SEQ only
		GLO = 4'h8,
		GHI = 4'h9,
		PLO = 4'hA,
		PHI = 4'hB,
		SEP = 4'hD,
		SEX = 4'hE,
		GROUP_F = 4'hF
	} opcode_t;

	// Low three bits of an F group instruction
	typedef enum logic [2:0] {
		LDX = 3'd0,     // also LDI
		OR = 3'd1,
		AND = 3'd2,
		XOR = 3'd3,
		ADD = 3'd4,
		SD = 3'd5,
		SHIFT = 3'd6,   // SHR, or SHL with bit 3
		SM = 3'd7
	} alu_op_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		MEM_WAIT,
		FINISH,
		IDLE
	} seq_state_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic write;
	} bus_req_t;

	// ROM only sees the lower half of the address space
	typedef struct packed {
		logic [ADDR_W-2:0] addr;
	} rom_req_t;

endpackage

//--- hw/cpu18_regfile.sv
`timescale 1ns/1ps

module cpu18_regfile (
	input logic clk,
	input logic rst_n,
	input logic [3:0] rd_sel,
	input logic [3:0] wr_sel,
	input logic [cpu18_pkg::ADDR_W-1:0] wr_data,
	input logic wr_lo,
	input logic wr_hi,
	input logic wr_en,
	input logic inc_p,
	input logic [3:0] p,
	output logic [cpu18_pkg::ADDR_W-1:0] rd_data,
	output logic [cpu18_pkg::ADDR_W-1:0] p_value
);

	logic [cpu18_pkg::ADDR_W-1:0] regs [cpu18_pkg::NUM_REGS];

	assign rd_data = regs[rd_sel];
	assign p_value = regs[p];

	// R0 is the program counter out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs[0] <= '0;
		end else begin
			// A direct write to R(P) wins over the increment
			if (inc_p && !(wr_en && wr_sel == p)) begin
				regs[p] <= p_value + 1'b1;
			end
			if (wr_en && wr_lo) begin
				regs[wr_sel][cpu18_pkg::DATA_W-1:0] <= wr_data[cpu18_pkg::DATA_W-1:0];
			end
			if (wr_en && wr_hi) begin
				regs[wr_sel][cpu18_pkg::ADDR_W-1:cpu18_pkg::DATA_W] <=
					wr_data[cpu18_pkg::ADDR_W-1:cpu18_pkg::DATA_W];
			end
		end
	end

endmodule

//--- hw/cpu18_alu.sv
`timescale 1ns/1ps

module cpu18_alu (
	input cpu18_pkg::alu_op_t op,
	input logic immediate_shift_left,
	input logic [cpu18_pkg::DATA_W-1:0] d,
	input logic df,
	input logic [cpu18_pkg::DATA_W-1:0] b,
	input logic q,
	input logic [3:0] cond,
	output logic [cpu18_pkg::DATA_W-1:0] alu_d,
	output logic alu_df,
	output logic branch_taken
);

	localparam int W = cpu18_pkg::DATA_W;

	logic [W:0] sum;
	logic [W:0] diff_bd;    // B - D, top bit is the borrow
	logic [W:0] diff_db;    // D - B
	logic cond_raw;

	assign sum = {1'b0, d} + {1'b0, b};
	assign diff_bd = {1'b0, b} - {1'b0, d};
	assign diff_db = {1'b0, d} - {1'b0, b};

	always_comb begin
		alu_d = d;
		alu_df = df;
		case (op)
			cpu18_pkg::LDX: alu_d = b;
			cpu18_pkg::OR: alu_d = d | b;
			cpu18_pkg::AND: alu_d = d & b;
			cpu18_pkg::XOR: alu_d = d ^ b;
			cpu18_pkg::ADD: begin
				alu_d = sum[W-1:0];
				alu_df = sum[W];
			end
			cpu18_pkg::SD: begin
				alu_d = diff_bd[W-1:0];
				alu_df = ~diff_bd[W];   // DF set means no borrow
			end
			cpu18_pkg::SHIFT: begin
				if (immediate_shift_left) begin
					alu_d = {d[W-2:0], 1'b0};
					alu_df = d[W-1];
				end else begin
					alu_d = {1'b0, d[W-1:1]};
					alu_df = d[0];
				end
			end
			cpu18_pkg::SM: begin
				alu_d = diff_db[W-1:0];
				alu_df = ~diff_db[W];
			end
			default: ;
		endcase
	end

	// Short branch test, EF codes are gone and never match
	always_comb begin
		case (cond[2:0])
			3'd0: cond_raw = 1'b1;
			3'd1: cond_raw = q;
			3'd2: cond_raw = (d == '0);
			3'd3: cond_raw = df;
			default: cond_raw = 1'b0;
		endcase
	end

	assign branch_taken = cond_raw ^ cond[3];

endmodule

//--- hw/cpu18_bus_unit.sv
`timescale 1ns/1ps

module cpu18_bus_unit (
	input logic clk,
	input logic rst_n,
	input cpu18_pkg::bus_req_t bus_req,
	input logic bus_req_valid,
	output logic bus_req_ready,
	output logic [cpu18_pkg::DATA_W-1:0] bus_rsp_data,
	output logic bus_rsp_valid,
	output cpu18_pkg::rom_req_t rom_req,
	output logic rom_req_valid,
	input logic rom_req_ready,
	input logic [cpu18_pkg::DATA_W-1:0] rom_data,
	input logic rom_data_valid,
	output logic rom_data_ready,
	output logic [cpu18_pkg::DATA_W-1:0] out_data,
	output logic out_valid,
	input logic out_ready
);

	localparam int RAM_AW = $clog2(cpu18_pkg::RAM_SIZE);

	typedef enum logic [2:0] {
		BU_IDLE,
		BU_ROM_REQ,
		BU_ROM_DATA,
		BU_OUT,
		BU_RSP
	} bu_state_t;

	bu_state_t state;
	cpu18_pkg::bus_req_t req_q;
	logic [cpu18_pkg::DATA_W-1:0] ram [cpu18_pkg::RAM_SIZE];
	logic [cpu18_pkg::ADDR_W-1:0] offset;
	logic [RAM_AW-1:0] ram_idx;
	logic accept;
	logic is_rom;
	logic is_out;
	logic is_ram;

	assign accept = bus_req_valid && bus_req_ready;

	// Address decode
	assign offset = bus_req.addr - cpu18_pkg::RAM_BASE;
	assign ram_idx = offset[RAM_AW-1:0];
	assign is_rom = !bus_req.addr[cpu18_pkg::ADDR_W-1];
	assign is_out = (bus_req.addr == cpu18_pkg::OUT_PORT_ADDR);
	assign is_ram = bus_req.addr[cpu18_pkg::ADDR_W-1] && (offset < cpu18_pkg::RAM_SIZE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= BU_IDLE;
		end else begin
			case (state)
				BU_IDLE: begin
					if (accept) begin
						if (is_rom && !bus_req.write) state <= BU_ROM_REQ;
						else if (is_out && bus_req.write) state <= BU_OUT;
						else state <= BU_RSP;   // RAM, or an ignored access
					end
				end
				BU_ROM_REQ: if (rom_req_ready) state <= BU_ROM_DATA;
				BU_ROM_DATA: if (rom_data_valid) state <= BU_RSP;
				BU_OUT: if (out_ready) state <= BU_RSP;
				default: state <= BU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= bus_req;
			bus_rsp_data <= '0;   // unmapped reads return zero
			if (is_ram && bus_req.write) ram[ram_idx] <= bus_req.wdata;
			if (is_ram && !bus_req.write) bus_rsp_data <= ram[ram_idx];
		end
		if (state == BU_ROM_DATA && rom_data_valid) begin
			bus_rsp_data <= rom_data;
		end
	end

	assign bus_req_ready = (state == BU_IDLE);
	assign bus_rsp_valid = (state == BU_RSP);
	assign rom_req_valid = (state == BU_ROM_REQ);
	assign rom_req.addr = req_q.addr[cpu18_pkg::ADDR_W-2:0];
	assign rom_data_ready = (state == BU_ROM_DATA);
	assign out_valid = (state == BU_OUT);
	assign out_data = req_q.wdata;

endmodule

//--- hw/cpu18_sequencer.sv
`timescale 1ns/1ps

module cpu18_sequencer (
	input logic clk,
	input logic rst_n,
	output cpu18_pkg::bus_req_t bus_req,
	output logic bus_req_valid,
	input logic bus_req_ready,
	input logic bus_rsp_valid,
	input logic [cpu18_pkg::DATA_W-1:0] bus_rsp_data,
	output logic [3:0] rd_sel,
	output logic [3:0] wr_sel,
	output logic [cpu18_pkg::ADDR_W-1:0] wr_data,
	output logic wr_lo,
	output logic wr_hi,
	output logic wr_en,
	output logic inc_p,
	output logic [3:0] p,
	input logic [cpu18_pkg::ADDR_W-1:0] rd_data,
	input logic [cpu18_pkg::ADDR_W-1:0] p_value,
	output logic [cpu18_pkg::DATA_W-1:0] d,
	output logic df,
	output logic [cpu18_pkg::DATA_W-1:0] b,
	output logic [cpu18_pkg::DATA_W-1:0] instr,
	output logic alu_exec,
	input logic [cpu18_pkg::DATA_W-1:0] alu_d,
	input logic alu_df,
	input logic branch_taken,
	output logic q,
	output logic idle
);

	// Where the byte of the open read goes
	typedef enum logic [1:0] {DST_NONE, DST_INSTR, DST_D, DST_B} dest_t;

	cpu18_pkg::seq_state_t state;
	cpu18_pkg::opcode_t opc;
	dest_t dest;
	dest_t req_dest;
	logic [3:0] x;
	logic [3:0] n;

	assign opc = cpu18_pkg::opcode_t'(instr[7:4]);
	assign n = instr[3:0];

	always_comb begin
		bus_req_valid = 1'b0;
		bus_req.addr = p_value;
		bus_req.wdata = d;
		bus_req.write = 1'b0;
		req_dest = DST_INSTR;
		rd_sel = n;
		wr_sel = n;
		wr_data = rd_data + 1'b1;
		wr_lo = 1'b1;
		wr_hi = 1'b1;
		wr_en = 1'b0;
		inc_p = 1'b0;
		alu_exec = 1'b0;
		case (state)
			cpu18_pkg::FETCH: begin
				bus_req_valid = 1'b1;
				inc_p = bus_req_ready;   // post-increment R(P)
			end
			cpu18_pkg::DECODE: begin
				case (opc)
					cpu18_pkg::IDL_LDN: begin
						bus_req_valid = (n != 4'h0);
						bus_req.addr = rd_data;
						req_dest = DST_D;
					end
					cpu18_pkg::INC: wr_en = 1'b1;
					cpu18_pkg::DEC: begin
						wr_en = 1'b1;
						wr_data = rd_data - 1'b1;
					end
					cpu18_pkg::BRANCH: begin
						bus_req_valid = 1'b1;
						inc_p = bus_req_ready;
						req_dest = DST_B;
					end
					cpu18_pkg::LDA: begin
						bus_req_valid = 1'b1;
						bus_req.addr = rd_data;
						req_dest = DST_D;
						wr_en = bus_req_ready;
					end
					cpu18_pkg::STR: begin
						bus_req_valid = 1'b1;
						bus_req.addr = rd_data;
						bus_req.write = 1'b1;
						req_dest = DST_NONE;
					end
					cpu18_pkg::PLO: begin
						wr_en = 1'b1;
						wr_hi = 1'b0;
						wr_data = {8'h00, d};
					end
					cpu18_pkg::PHI: begin
						wr_en = 1'b1;
						wr_lo = 1'b0;
						wr_data = {d, 8'h00};
					end
					cpu18_pkg::GROUP_F: begin
						if (instr[2:0] == cpu18_pkg::SHIFT) begin
							alu_exec = 1'b1;   // shifts need no operand
						end else begin
							bus_req_valid = 1'b1;
							req_dest = DST_B;
							if (instr[3]) begin
								inc_p = bus_req_ready;   // immediate byte at R(P)
							end else begin
								rd_sel = x;
								bus_req.addr = rd_data;
							end
						end
					end
					default: ;
				endcase
			end
			cpu18_pkg::FINISH: begin
				alu_exec = (opc == cpu18_pkg::GROUP_F);
				if (opc == cpu18_pkg::BRANCH && branch_taken) begin
					wr_sel = p;
					wr_en = 1'b1;
					wr_hi = 1'b0;
					wr_data = {8'h00, b};
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= cpu18_pkg::FINISH;   // instr clear, so no request in reset
			dest <= DST_NONE;
			instr <= '0;
			x <= '0;
			p <= '0;
			d <= '0;
			df <= 1'b0;
			q <= 1'b0;
			idle <= 1'b0;
		end else begin
			if (alu_exec) begin
				d <= alu_d;
				df <= alu_df;
			end
			case (state)
				cpu18_pkg::FETCH: begin
					if (bus_req_ready) begin
						dest <= req_dest;
						state <= cpu18_pkg::MEM_WAIT;
					end
				end
				cpu18_pkg::DECODE: begin
					if (bus_req_valid) begin
						if (bus_req_ready) begin
							dest <= req_dest;
							state <= cpu18_pkg::MEM_WAIT;
						end
					end else begin
						state <= cpu18_pkg::FETCH;
						case (opc)
							cpu18_pkg::IDL_LDN: begin
								idle <= 1'b1;
								state <= cpu18_pkg::IDLE;
							end
							cpu18_pkg::GROUP7: begin
								if (n == 4'hA) q <= 1'b0;   // REQ
								if (n == 4'hB) q <= 1'b1;   // SEQ
							end
							cpu18_pkg::GLO: d <= rd_data[7:0];
							cpu18_pkg::GHI: d <= rd_data[15:8];
							cpu18_pkg::SEP: p <= n;
							cpu18_pkg::SEX: x <= n;
							default: ;
						endcase
					end
				end
				cpu18_pkg::MEM_WAIT: begin
					if (bus_rsp_valid) begin
						case (dest)
							DST_INSTR: begin
								instr <= bus_rsp_data;
								state <= cpu18_pkg::DECODE;
							end
							DST_D: begin
								d <= bus_rsp_data;
								state <= cpu18_pkg::FETCH;
							end
							DST_B: state <= cpu18_pkg::FINISH;
							default: state <= cpu18_pkg::FETCH;
						endcase
					end
				end
				cpu18_pkg::FINISH: state <= cpu18_pkg::FETCH;
				default: ;   // IDLE holds until reset
			endcase
		end
	end

	// Operand and branch byte
	always_ff @(posedge clk) begin
		if (state == cpu18_pkg::MEM_WAIT && bus_rsp_valid && dest == DST_B) begin
			b <= bus_rsp_data;
		end
	end

endmodule

//--- hw/cpu18_top.sv
`timescale 1ns/1ps

module cpu18_top (
	input logic clk,
	input logic rst_n,
	output cpu18_pkg::rom_req_t rom_req,
	output logic rom_req_valid,
	input logic rom_req_ready,
	input logic [cpu18_pkg::DATA_W-1:0] rom_data,
	input logic rom_data_valid,
	output logic rom_data_ready,
	output logic [cpu18_pkg::DATA_W-1:0] out_data,
	output logic out_valid,
	input logic out_ready,
	output logic q,
	output logic idle
);

	cpu18_pkg::bus_req_t bus_req;
	logic bus_req_valid;
	logic bus_req_ready;
	logic [cpu18_pkg::DATA_W-1:0] bus_rsp_data;
	logic bus_rsp_valid;
	logic [3:0] rd_sel;
	logic [3:0] wr_sel;
	logic [cpu18_pkg::ADDR_W-1:0] wr_data;
	logic wr_lo;
	logic wr_hi;
	logic wr_en;
	logic inc_p;
	logic [3:0] p;
	logic [cpu18_pkg::ADDR_W-1:0] rd_data;
	logic [cpu18_pkg::ADDR_W-1:0] p_value;
	logic [cpu18_pkg::DATA_W-1:0] d;
	logic df;
	logic [cpu18_pkg::DATA_W-1:0] b;
	logic [cpu18_pkg::DATA_W-1:0] instr;
	logic alu_exec;
	logic [cpu18_pkg::DATA_W-1:0] alu_d;
	logic alu_df;
	logic branch_taken;

	cpu18_sequencer sequencer_i (
		.clk(clk), .rst_n(rst_n),
		.bus_req(bus_req), .bus_req_valid(bus_req_valid), .bus_req_ready(bus_req_ready),
		.bus_rsp_valid(bus_rsp_valid), .bus_rsp_data(bus_rsp_data),
		.rd_sel(rd_sel), .wr_sel(wr_sel), .wr_data(wr_data),
		.wr_lo(wr_lo), .wr_hi(wr_hi), .wr_en(wr_en), .inc_p(inc_p), .p(p),
		.rd_data(rd_data), .p_value(p_value),
		.d(d), .df(df), .b(b), .instr(instr), .alu_exec(alu_exec),
		.alu_d(alu_d), .alu_df(alu_df), .branch_taken(branch_taken),
		.q(q), .idle(idle)
	);

	cpu18_regfile regfile_i (
		.clk(clk), .rst_n(rst_n),
		.rd_sel(rd_sel), .wr_sel(wr_sel), .wr_data(wr_data),
		.wr_lo(wr_lo), .wr_hi(wr_hi), .wr_en(wr_en), .inc_p(inc_p), .p(p),
		.rd_data(rd_data), .p_value(p_value)
	);

	// Operation and branch field come straight from the instruction latch
	cpu18_alu alu_i (
		.op(cpu18_pkg::alu_op_t'(instr[2:0])), .immediate_shift_left(instr[3]),
		.d(d), .df(df), .b(b), .q(q), .cond(instr[3:0]),
		.alu_d(alu_d), .alu_df(alu_df), .branch_taken(branch_taken)
	);

	cpu18_bus_unit bus_unit_i (
		.clk(clk), .rst_n(rst_n),
		.bus_req(bus_req), .bus_req_valid(bus_req_valid), .bus_req_ready(bus_req_ready),
		.bus_rsp_data(bus_rsp_data), .bus_rsp_valid(bus_rsp_valid),
		.rom_req(rom_req), .rom_req_valid(rom_req_valid), .rom_req_ready(rom_req_ready),
		.rom_data(rom_data), .rom_data_valid(rom_data_valid), .rom_data_ready(rom_data_ready),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
	);

endmodule

//--- bench/cpu18_assertions.sv
`timescale 1ns/1ps

module cpu18_assertions (
	input logic clk,
	input logic rst_n,
	input cpu18_pkg::rom_req_t rom_req,
	input logic rom_req_valid,
	input logic rom_req_ready,
	input logic rom_data_valid,
	input logic rom_data_ready,
	input logic [cpu18_pkg::DATA_W-1:0] out_data,
	input logic out_valid,
	input logic out_ready,
	input logic idle
);

	int fail_count = 0;

	rom_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		rom_req_valid && !rom_req_ready |=> rom_req_valid && $stable(rom_req))
	else begin
		fail_count++;
		$error("rom_req changed while the ROM stalled");
	end

	// Data beat only while the bus unit waits for it
	rom_data_taken: assert property (@(posedge clk) disable iff (!rst_n)
		rom_data_valid |-> rom_data_ready)
	else begin
		fail_count++;
		$error("ROM data arrived while rom_data_ready was low");
	end

	out_data_held: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
	else begin
		fail_count++;
		$error("out_data changed while the port stalled");
	end

	// No more fetches once IDL parks the machine
	no_fetch_idle: assert property (@(posedge clk) disable iff (!rst_n)
		idle |-> !rom_req_valid)
	else begin
		fail_count++;
		$error("ROM request raised while idle");
	end

endmodule

//--- bench/cpu18_checker.sv
`timescale 1ns/1ps

module cpu18_checker (
	input logic clk,
	input logic rst_n,
	input logic [7:0] out_data,
	input logic out_valid,
	input logic out_ready,
	input logic q,
	input logic idle
);

	logic [8:0] expected [$];   // {q, out_data} per transfer
	int errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	task automatic expect_out(input logic [8:0] value);
		expected.push_back(value);
	endtask

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	always @(posedge clk) begin
		logic [8:0] want;
		if (rst_n && out_valid && out_ready) begin
			if (idle) begin
				$display("Out transfer of %02h at %0t after the DUT went idle", out_data, $time);
				count_error();
			end
			if (expected.size() == 0) begin
				$display("Unexpected out transfer of %02h at %0t", out_data, $time);
				count_error();
			end else begin
				want = expected.pop_front();
				if (out_data !== want[7:0]) begin
					$display("** Error at %0t: out_data expected %02h, got %02h",
						$time, want[7:0], out_data);
					count_error();
				end
				if (q !== want[8]) begin
					$display("** Error at %0t: q expected %b, got %b", $time, want[8], q);
					count_error();
				end
			end
		end
	end

	task automatic finish_test(input string name);
		if (expected.size() != 0) begin
			$display("%0d expected out transfers never arrived", expected.size());
			count_error();
		end
		if (idle !== 1'b1) begin
			$display("The DUT did not reach idle at the end of the program");
			count_error();
		end
		if (q !== 1'b0) begin
			$display("** Error at %0t: q expected 0, got %b", $time, q);
			count_error();
		end
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("Test %0d %s: %s", tests_run, name, (test_errors == 0) ? "ok" : "failed");
		test_errors = 0;
		expected.delete();
	endtask

endmodule

//--- bench/cpu18_tb.sv
`timescale 1ns/1ps

module cpu18_tb;

	localparam int ALU_CASES = 30;
	localparam int BRANCH_CASES = 10;
	localparam int REG_CASES = 8;
	localparam int RAM_CASES = 4;
	localparam int RAM_BYTES = 4;
	localparam int NUM_TESTS = 2 * ALU_CASES + BRANCH_CASES + REG_CASES + RAM_CASES + 1;
	localparam int CYCLES_PER_TEST = 20000;

	logic clk = 1'b0;
	logic rst_n;
	cpu18_pkg::rom_req_t rom_req;
	logic rom_req_valid;
	logic rom_req_ready;
	logic [7:0] rom_data;
	logic rom_data_valid;
	logic rom_data_ready;
	logic [7:0] out_data;
	logic out_valid;
	logic out_ready;
	logic q;
	logic idle;
	logic stall;                // random out_ready drops
	logic [7:0] prog [$];
	logic [7:0] alu_ops [8] = '{8'hF9, 8'hFA, 8'hFB, 8'hFC, 8'hFD, 8'hFF, 8'hFE, 8'hF6};
	logic [7:0] case_op [ALU_CASES];
	logic [7:0] case_a [ALU_CASES];
	logic [7:0] case_b [ALU_CASES];
	int total_errors;

	always #20 clk = ~clk;

	cpu18_top cpu18_top_i (
		.clk(clk), .rst_n(rst_n),
		.rom_req(rom_req), .rom_req_valid(rom_req_valid), .rom_req_ready(rom_req_ready),
		.rom_data(rom_data), .rom_data_valid(rom_data_valid), .rom_data_ready(rom_data_ready),
		.out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
		.q(q), .idle(idle)
	);

	cpu18_checker checker_i (
		.clk(clk), .rst_n(rst_n), .out_data(out_data), .out_valid(out_valid),
		.out_ready(out_ready), .q(q), .idle(idle)
	);

	bind cpu18_top cpu18_assertions assertions_i (
		.clk(clk), .rst_n(rst_n), .rom_req(rom_req), .rom_req_valid(rom_req_valid),
		.rom_req_ready(rom_req_ready), .rom_data_valid(rom_data_valid),
		.rom_data_ready(rom_data_ready), .out_data(out_data), .out_valid(out_valid),
		.out_ready(out_ready), .idle(idle)
	);

	// Expected {DF, D} of an F group instruction
	function automatic logic [8:0] alu_ref(input logic [7:0] opc, input logic [7:0] d_in,
		input logic df_in, input logic [7:0] m);
		logic [8:0] r;
		case (opc[2:0])
			3'd0: r = {df_in, m};
			3'd1: r = {df_in, d_in | m};
			3'd2: r = {df_in, d_in & m};
			3'd3: r = {df_in, d_in ^ m};
			3'd4: r = {1'b0, d_in} + {1'b0, m};   // carry lands in DF
			3'd5: r = {m >= d_in, m - d_in};
			3'd6: r = opc[3] ? {d_in[7], d_in << 1} : {d_in[0], d_in >> 1};
			default: r = {d_in >= m, d_in - m};
		endcase
		return r;
	endfunction

	function automatic logic branch_ref(input logic [7:0] opc, input logic [7:0] d_in,
		input logic df_in);
		logic t;
		case (opc[2:0])
			3'd0: t = 1'b1;
			3'd1: t = 1'b0;     // Q stays low in these programs
			3'd2: t = (d_in == 8'h00);
			3'd3: t = df_in;
			default: t = 1'b0;
		endcase
		return opc[3] ? !t : t;
	endfunction

	function automatic logic [7:0] rom_byte(input logic [14:0] addr);
		if (addr < prog.size()) return prog[addr];
		return 8'h00;   // IDL past the end
	endfunction

	task automatic emit(input logic [7:0] value);
		prog.push_back(value);
	endtask

	task automatic load_reg(input logic [3:0] r, input logic [15:0] value);
		emit(8'hF8);
		emit(value[15:8]);
		emit({4'hB, r});    // PHI
		emit(8'hF8);
		emit(value[7:0]);
		emit({4'hA, r});    // PLO
	endtask

	// Reset stays low while the new program goes in
	task automatic begin_program();
		@(negedge clk);
		rst_n = 1'b0;
		prog.delete();
		load_reg(4'd3, cpu18_pkg::OUT_PORT_ADDR);   // R3 points at the out port
	endtask

	task automatic run_program(input string name);
		emit(8'h00);
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		do @(negedge clk); while (!idle);
		repeat (8) @(negedge clk);   // window for stray transfers
		checker_i.finish_test(name);
	endtask

	task automatic run_alu_case(input int i, input string name);
		logic [8:0] r;
		begin_program();
		emit(8'hF8);
		emit(case_a[i]);
		emit(case_op[i]);
		if (case_op[i][2:0] != 3'd6) emit(case_b[i]);
		emit(8'h53);
		r = alu_ref(case_op[i], case_a[i], 1'b0, case_b[i]);
		checker_i.expect_out({1'b0, r[7:0]});
		run_program(name);
	endtask

	task automatic run_branch_case(input int i);
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] op;
		logic [7:0] br;
		logic [8:0] r;
		int k;
		a = 8'($urandom);
		b = 8'($urandom);
		if (i < 8) begin
			op = (i % 3 == 0) ? 8'hFC : (i % 3 == 1) ? 8'hFD : 8'hFF;
			br = (i % 2 == 1) ? 8'h3B : 8'h33;   // BNF or BDF
		end else begin
			op = 8'hFA;
			br = (i == 8) ? 8'h32 : 8'h3A;
			if (i == 8) b = 8'h00;
		end
		begin_program();
		emit(8'hF8);
		emit(a);
		emit(op);
		emit(b);
		emit(br);
		k = prog.size();
		emit(8'(k + 5));
		emit(8'hF8);
		emit(8'h00);
		emit(8'h30);
		emit(8'(k + 7));
		emit(8'hF8);
		emit(8'h01);        // taken path
		emit(8'h53);
		r = alu_ref(op, a, 1'b0, b);
		checker_i.expect_out({8'h00, branch_ref(br, r[7:0], r[8])});
		run_program($sformatf("branch %0d op %02h br %02h", i, op, br));
	endtask

	task automatic run_reg_case(input int i);
		logic [15:0] v;
		logic [15:0] e;
		logic up;
		v = 16'($urandom);
		up = (i % 2 == 0);
		if (i == 0) v = 16'hFFFF;
		if (i == 1) v = 16'h0000;
		e = up ? v + 16'd1 : v - 16'd1;
		begin_program();
		load_reg(4'd4, v);
		emit(up ? 8'h14 : 8'h24);
		emit(8'h84);
		emit(8'h53);
		emit(8'h94);
		emit(8'h53);
		checker_i.expect_out({1'b0, e[7:0]});
		checker_i.expect_out({1'b0, e[15:8]});
		run_program($sformatf("register %0d value %04h", i, v));
	endtask

	task automatic run_ram_case(input int i);
		logic [7:0] vals [RAM_BYTES];
		logic [15:0] addr;
		addr = cpu18_pkg::RAM_BASE + 16'($urandom % (cpu18_pkg::RAM_SIZE - RAM_BYTES));
		begin_program();
		load_reg(4'd4, addr);
		load_reg(4'd5, addr);
		load_reg(4'd6, addr);
		for (int j = 0; j < RAM_BYTES; j++) begin
			vals[j] = 8'($urandom);
			emit(8'hF8);
			emit(vals[j]);
			emit(8'h54);    // STR R4
			emit(8'h14);
		end
		for (int j = 0; j < RAM_BYTES; j++) begin
			emit(8'h45);    // LDA R5
			emit(8'h53);
			checker_i.expect_out({1'b0, vals[j]});
		end
		emit(8'hE6);
		emit(8'hF0);        // LDX through R6
		emit(8'h53);
		checker_i.expect_out({1'b0, vals[0]});
		run_program($sformatf("ram %0d address %04h", i, addr));
	endtask

	task automatic run_q_case();
		logic [7:0] v;
		v = 8'($urandom);
		begin_program();
		emit(8'h7B);
		emit(8'hF8);
		emit(v);
		emit(8'h53);
		emit(8'h7A);
		checker_i.expect_out({1'b1, v});
		run_program("q and idle");
	endtask

	// ROM model with one data beat per request
	initial begin
		logic [14:0] fetch_addr;
		rom_req_ready = 1'b0;
		rom_data_valid = 1'b0;
		rom_data = 8'h00;
		forever begin
			@(negedge clk);
			rom_req_ready = 1'b0;
			rom_data_valid = 1'b0;
			if (rst_n && rom_req_valid) begin
				repeat ($urandom % 4) @(negedge clk);
				rom_req_ready = 1'b1;
				fetch_addr = rom_req.addr;
				@(negedge clk);
				rom_req_ready = 1'b0;
				repeat ($urandom % 4) @(negedge clk);
				rom_data = rom_byte(fetch_addr);
				rom_data_valid = 1'b1;
			end
		end
	end

	initial begin
		out_ready = 1'b1;
		forever begin
			@(negedge clk);
			out_ready = !stall || ($urandom % 2 == 1);
		end
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog timeout after %0d cycles, the DUT stopped making progress",
			NUM_TESTS * CYCLES_PER_TEST);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		void'($urandom(76688));
		rst_n = 1'b0;
		stall = 1'b0;
		for (int i = 0; i < ALU_CASES; i++) begin
			case_op[i] = alu_ops[i % 8];
			case_a[i] = 8'($urandom);
			case_b[i] = 8'($urandom);
		end
		for (int i = 0; i < ALU_CASES; i++) run_alu_case(i, $sformatf("alu %0d", i));
		for (int i = 0; i < BRANCH_CASES; i++) run_branch_case(i);
		for (int i = 0; i < REG_CASES; i++) run_reg_case(i);
		for (int i = 0; i < RAM_CASES; i++) run_ram_case(i);
		run_q_case();
		stall = 1'b1;
		for (int i = 0; i < ALU_CASES; i++) run_alu_case(i, $sformatf("stalled alu %0d", i));
		total_errors = checker_i.errors + cpu18_top_i.assertions_i.fail_count;
		$display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d",
			checker_i.tests_run, checker_i.tests_failed, checker_i.errors,
			cpu18_top_i.assertions_i.fail_count);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- filelist.f
hw/cpu18_pkg.sv
hw/cpu18_regfile.sv
hw/cpu18_alu.sv
hw/cpu18_bus_unit.sv
hw/cpu18_sequencer.sv
hw/cpu18_top.sv
bench/cpu18_assertions.sv
bench/cpu18_checker.sv
bench/cpu18_tb.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module cpu18_tb \
	-o cpu18_sim &&
./obj_dir/cpu18_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }
